// ==== Bender.yml ====
package:
  name: idStage

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/decodePkg.sv
      - hdl/controlDecoder.sv
      - hdl/registerFile.sv
      - hdl/hazardDetector.sv
      - hdl/operandSelect.sv
      - hdl/idStage.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - tests/idStageTb.sv

// ==== hdl/controlDecoder.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "decode_consts.svh"

module controlDecoder (
    input  decodePkg::instrWord    instr,
    input  logic                   controlStall,   // From hazard detector
    output logic [`DATA_WIDTH-1:0] controlWord,
    output logic                   isBranch,
    output logic                   immZero         // Zero-extend the immediate
);

    logic       known;      // Opcode is in the table
    logic       aluSrcB;
    logic [1:0] regDst;
    logic [1:0] byteSize;
    logic       memWrite;
    logic       memRead;
    logic       regWrite;
    logic [1:0] memToReg;

    // ------------------------------------------------------------------------
    // Opcode decode
    // ------------------------------------------------------------------------
    always_comb begin
        known    = 1'b1;
        aluSrcB  = 1'b0;
        regDst   = `REGDST_RT;
        byteSize = `SIZE_WORD;
        memWrite = 1'b0;
        memRead  = 1'b0;
        regWrite = 1'b0;
        memToReg = `MEMTOREG_ALU;
        case (instr.rType.opcode)
            `OP_RTYPE: begin
                regDst   = `REGDST_RD;
                regWrite = 1'b1;
            end
            `OP_ADDI, `OP_ANDI, `OP_ORI, `OP_XORI: begin
                aluSrcB  = 1'b1;
                regWrite = 1'b1;
            end
            `OP_LW, `OP_LH, `OP_LB: begin
                aluSrcB  = 1'b1;
                memRead  = 1'b1;
                regWrite = 1'b1;
                memToReg = `MEMTOREG_MEM;
                if (instr.rType.opcode == `OP_LH)
                    byteSize = `SIZE_HALF;
                else if (instr.rType.opcode == `OP_LB)
                    byteSize = `SIZE_BYTE;
            end
            `OP_SW, `OP_SH, `OP_SB: begin
                aluSrcB  = 1'b1;
                memWrite = 1'b1;
                if (instr.rType.opcode == `OP_SH)
                    byteSize = `SIZE_HALF;
                else if (instr.rType.opcode == `OP_SB)
                    byteSize = `SIZE_BYTE;
            end
            `OP_BEQ, `OP_BNE: ;                 // aluOp only
            `OP_JAL: begin
                regDst   = `REGDST_R31;
                regWrite = 1'b1;
                memToReg = `MEMTOREG_LINK;
            end
            default: known = 1'b0;              // Unknown, all zero
        endcase
    end

    // Pack fields, a stall squashes the whole word
    always_comb begin
        controlWord = '0;
        if (known && !controlStall) begin
            controlWord[`CW_ALUOP]    = instr.rType.opcode;
            controlWord[`CW_ALUSRCB]  = aluSrcB;
            controlWord[`CW_REGDST]   = regDst;
            controlWord[`CW_BYTESIZE] = byteSize;
            controlWord[`CW_MEMWRITE] = memWrite;
            controlWord[`CW_MEMREAD]  = memRead;
            controlWord[`CW_REGWRITE] = regWrite;
            controlWord[`CW_MEMTOREG] = memToReg;
        end
    end

    assign isBranch = (instr.rType.opcode == `OP_BEQ) || (instr.rType.opcode == `OP_BNE);
    assign immZero  = (instr.rType.opcode == `OP_ANDI) || (instr.rType.opcode == `OP_ORI)
                   || (instr.rType.opcode == `OP_XORI);   // Logical ops

endmodule

`default_nettype wire

// ==== hdl/decodePkg.sv ====
`default_nettype none

`include "decode_consts.svh"

package decodePkg;

    // R-type view, register to register
    typedef struct packed {
        logic [`OPCODE_WIDTH-1:0]   opcode;
        logic [`REG_ADDR_WIDTH-1:0] rs;
        logic [`REG_ADDR_WIDTH-1:0] rt;
        logic [`REG_ADDR_WIDTH-1:0] rd;
        logic [`REG_ADDR_WIDTH-1:0] shamt;
        logic [5:0]                 funct;     // ALU function code
    } rTypeFields;

    // I-type view, immediates, loads, stores, branches
    typedef struct packed {
        logic [`OPCODE_WIDTH-1:0]   opcode;
        logic [`REG_ADDR_WIDTH-1:0] rs;
        logic [`REG_ADDR_WIDTH-1:0] rt;
        logic [`IMM_WIDTH-1:0]      imm;
    } iTypeFields;

    // Same 32-bit word, two readings
    typedef union packed {
        rTypeFields rType;
        iTypeFields iType;
    } instrWord;

endpackage

`default_nettype wire

// ==== hdl/decode_consts.svh ====
`ifndef DECODE_CONSTS_SVH
`define DECODE_CONSTS_SVH

// ------------------------------------------------------------------------
// Widths
// ------------------------------------------------------------------------
`define DATA_WIDTH      32
`define REG_ADDR_WIDTH  5
`define OPCODE_WIDTH    6
`define IMM_WIDTH       16
`define REG_LINK        5'd31       // jal destination

// ------------------------------------------------------------------------
// Opcodes, MIPS numbering
// ------------------------------------------------------------------------
`define OP_RTYPE    6'h00
`define OP_JAL      6'h03
`define OP_BEQ      6'h04
`define OP_BNE      6'h05
`define OP_ADDI     6'h08
`define OP_ANDI     6'h0C
`define OP_ORI      6'h0D
`define OP_XORI     6'h0E
`define OP_LB       6'h20
`define OP_LH       6'h21
`define OP_LW       6'h23
`define OP_SB       6'h28
`define OP_SH       6'h29
`define OP_SW       6'h2B

// ------------------------------------------------------------------------
// Control word fields, bits above 17 stay zero
// ------------------------------------------------------------------------
`define CW_ALUOP    17:12
`define CW_ALUSRCB  11
`define CW_REGDST   10:9
`define CW_BYTESIZE 8:7
`define CW_MEMWRITE 6
`define CW_MEMREAD  5
`define CW_REGWRITE 2
`define CW_MEMTOREG 1:0

// Field encodings
`define REGDST_RT       2'd0
`define REGDST_RD       2'd1
`define REGDST_R31      2'd2
`define SIZE_WORD       2'd0
`define SIZE_HALF       2'd1
`define SIZE_BYTE       2'd2
`define MEMTOREG_ALU    2'd0
`define MEMTOREG_MEM    2'd1
`define MEMTOREG_LINK   2'd2

`endif

// ==== hdl/hazardDetector.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "decode_consts.svh"

module hazardDetector (
    input  decodePkg::instrWord        instr,
    input  logic                       isBranch,
    input  logic                       memReadIdEx,       // Load in EX
    input  logic                       regWriteIdEx,
    input  logic [1:0]                 regDstIdEx,
    input  logic [`REG_ADDR_WIDTH-1:0] regRtIdEx,
    input  logic [`REG_ADDR_WIDTH-1:0] regRdIdEx,
    input  logic                       regWriteExMem,
    input  logic                       memReadExMem,      // Load in MEM
    input  logic [`REG_ADDR_WIDTH-1:0] registerDstExMem,
    output logic                       controlStall,
    output logic                       pcWrite,
    output logic                       ifIdWrite
);

    logic [`REG_ADDR_WIDTH-1:0] dstIdEx;     // Destination of the instruction in EX
    logic                       loadUse;
    logic                       branchIdEx;  // Branch source still in EX
    logic                       branchExMem; // Branch source loading in MEM
    logic                       loadExMem;

    always_comb begin
        case (regDstIdEx)
            `REGDST_RD:  dstIdEx = regRdIdEx;
            `REGDST_R31: dstIdEx = `REG_LINK;
            default:     dstIdEx = regRtIdEx;
        endcase
    end

    // Loaded value not ready until after MEM
    assign loadUse = memReadIdEx && (regRtIdEx != '0)
                  && ((regRtIdEx == instr.iType.rs) || (regRtIdEx == instr.iType.rt));

    // Branch compares in ID, so any pending write to a source stalls
    assign branchIdEx  = regWriteIdEx
                      && (((instr.iType.rs != '0) && (instr.iType.rs == dstIdEx))
                       || ((instr.iType.rt != '0) && (instr.iType.rt == dstIdEx)));
    assign loadExMem   = regWriteExMem && memReadExMem;
    assign branchExMem = loadExMem
                      && (((instr.iType.rs != '0) && (instr.iType.rs == registerDstExMem))
                       || ((instr.iType.rt != '0) && (instr.iType.rt == registerDstExMem)));

    assign controlStall = loadUse || (isBranch && (branchIdEx || branchExMem));
    assign pcWrite      = !controlStall;     // Hold PC
    assign ifIdWrite    = !controlStall;     // Hold IF/ID

endmodule

`default_nettype wire

// ==== hdl/idStage.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "decode_consts.svh"

module idStage (
    input  logic                       Clock,
    input  logic                       reset,
    input  decodePkg::instrWord        instr,             // From IF/ID
    // Writeback port
    input  logic                       regWrite,
    input  logic [`REG_ADDR_WIDTH-1:0] writeRegister,
    input  logic [`DATA_WIDTH-1:0]     writeData,
    // Forwarding unit
    input  logic [`DATA_WIDTH-1:0]     forwardDataExMem,
    input  logic                       forwardMuxASel,
    input  logic                       forwardMuxBSel,
    // ID/EX state
    input  logic                       memReadIdEx,
    input  logic                       regWriteIdEx,
    input  logic [1:0]                 regDstIdEx,
    input  logic [`REG_ADDR_WIDTH-1:0] regRtIdEx,
    input  logic [`REG_ADDR_WIDTH-1:0] regRdIdEx,
    // EX/MEM state
    input  logic                       regWriteExMem,
    input  logic                       memReadExMem,
    input  logic [`REG_ADDR_WIDTH-1:0] registerDstExMem,
    // Outputs
    output logic [`DATA_WIDTH-1:0]     controlWord,
    output logic [`DATA_WIDTH-1:0]     readData1Out,
    output logic [`DATA_WIDTH-1:0]     readData2Out,
    output logic [`DATA_WIDTH-1:0]     immediate,
    output logic                       pcWrite,
    output logic                       ifIdWrite
);

    logic                   isBranch;
    logic                   immZero;
    logic                   controlStall;   // Squashes the control word
    logic [`DATA_WIDTH-1:0] readData1;
    logic [`DATA_WIDTH-1:0] readData2;

    controlDecoder decoder (
        .instr        (instr),
        .controlStall (controlStall),
        .controlWord  (controlWord),
        .isBranch     (isBranch),
        .immZero      (immZero)
    );

    registerFile regFile (
        .Clock         (Clock),
        .reset         (reset),
        .readRegister1 (instr.rType.rs),
        .readRegister2 (instr.rType.rt),
        .writeRegister (writeRegister),
        .writeData     (writeData),
        .regWrite      (regWrite),
        .readData1     (readData1),
        .readData2     (readData2)
    );

    hazardDetector hazards (
        .instr            (instr),
        .isBranch         (isBranch),         // Opcode only, no loop
        .memReadIdEx      (memReadIdEx),
        .regWriteIdEx     (regWriteIdEx),
        .regDstIdEx       (regDstIdEx),
        .regRtIdEx        (regRtIdEx),
        .regRdIdEx        (regRdIdEx),
        .regWriteExMem    (regWriteExMem),
        .memReadExMem     (memReadExMem),
        .registerDstExMem (registerDstExMem),
        .controlStall     (controlStall),
        .pcWrite          (pcWrite),
        .ifIdWrite        (ifIdWrite)
    );

    operandSelect operands (
        .instr            (instr),
        .readData1        (readData1),
        .readData2        (readData2),
        .forwardDataExMem (forwardDataExMem),
        .forwardMuxASel   (forwardMuxASel),
        .forwardMuxBSel   (forwardMuxBSel),
        .immZero          (immZero),
        .readData1Out     (readData1Out),
        .readData2Out     (readData2Out),
        .immediate        (immediate)
    );

endmodule

`default_nettype wire

// ==== hdl/operandSelect.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "decode_consts.svh"

module operandSelect (
    input  decodePkg::instrWord    instr,
    input  logic [`DATA_WIDTH-1:0] readData1,
    input  logic [`DATA_WIDTH-1:0] readData2,
    input  logic [`DATA_WIDTH-1:0] forwardDataExMem,  // Result from EX/MEM
    input  logic                   forwardMuxASel,
    input  logic                   forwardMuxBSel,
    input  logic                   immZero,
    output logic [`DATA_WIDTH-1:0] readData1Out,
    output logic [`DATA_WIDTH-1:0] readData2Out,
    output logic [`DATA_WIDTH-1:0] immediate
);

    logic [`DATA_WIDTH-1:0] immSigned;
    logic [`DATA_WIDTH-1:0] immUnsigned;

    // ------------------------------------------------------------------------
    // Forwarding muxes
    // ------------------------------------------------------------------------
    assign readData1Out = forwardMuxASel ? forwardDataExMem : readData1;   // rs
    assign readData2Out = forwardMuxBSel ? forwardDataExMem : readData2;   // rt

    // ------------------------------------------------------------------------
    // Immediate extension
    // ------------------------------------------------------------------------
    assign immSigned   = {{(`DATA_WIDTH-`IMM_WIDTH){instr.iType.imm[`IMM_WIDTH-1]}},
                          instr.iType.imm};
    assign immUnsigned = {{(`DATA_WIDTH-`IMM_WIDTH){1'b0}}, instr.iType.imm};

    // Logical ops take zero extension
    assign immediate = immZero ? immUnsigned : immSigned;

endmodule

`default_nettype wire

// ==== hdl/registerFile.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "decode_consts.svh"

module registerFile (
    input  logic                       Clock,
    input  logic                       reset,
    input  logic [`REG_ADDR_WIDTH-1:0] readRegister1,   // rs
    input  logic [`REG_ADDR_WIDTH-1:0] readRegister2,   // rt
    input  logic [`REG_ADDR_WIDTH-1:0] writeRegister,
    input  logic [`DATA_WIDTH-1:0]     writeData,
    input  logic                       regWrite,
    output logic [`DATA_WIDTH-1:0]     readData1,
    output logic [`DATA_WIDTH-1:0]     readData2
);

    logic [`DATA_WIDTH-1:0] regs [0:(1 << `REG_ADDR_WIDTH)-1];
    logic                   writing;     // Real write this cycle

    assign writing = regWrite && (writeRegister != '0);   // r0 never written

    // Write port
    always_ff @(posedge Clock) begin
        if (reset) begin
            for (int i = 0; i < (1 << `REG_ADDR_WIDTH); i++)
                regs[i] <= '0;
        end else if (writing) begin
            regs[writeRegister] <= writeData;
        end
    end

    // Reads, r0 first, then write-through bypass
    assign readData1 = (readRegister1 == '0)                        ? '0        :
                       (writing && (writeRegister == readRegister1)) ? writeData :
                                                                       regs[readRegister1];
    assign readData2 = (readRegister2 == '0)                        ? '0        :
                       (writing && (writeRegister == readRegister2)) ? writeData :
                                                                       regs[readRegister2];

endmodule

`default_nettype wire

// ==== idStage.f ====
+incdir+hdl
hdl/decodePkg.sv
hdl/controlDecoder.sv
hdl/registerFile.sv
hdl/hazardDetector.sv
hdl/operandSelect.sv
hdl/idStage.sv
tests/idStageTb.sv

// ==== tests/idStageTb.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "decode_consts.svh"

module idStageTb;

    // Cycles per test for the watchdog budget
    localparam int RESET_CYCLES   = 3;
    localparam int REGFILE_CYCLES = 32 + 8;
    localparam int RANDOM_CYCLES  = 64 * 2;
    localparam int CONTROL_CYCLES = 15;
    localparam int HAZARD_CYCLES  = 12;
    localparam int FORWARD_CYCLES = 4;
    localparam int IMM_CYCLES     = 7 * 8;
    localparam int TOTAL_CYCLES   = RESET_CYCLES + REGFILE_CYCLES + RANDOM_CYCLES
                                  + CONTROL_CYCLES + HAZARD_CYCLES + FORWARD_CYCLES
                                  + IMM_CYCLES + 20;                  // Margin

    logic                       Clock = 1'b0;
    logic                       reset;
    logic [`DATA_WIDTH-1:0]     instr;
    logic                       regWrite;
    logic [`REG_ADDR_WIDTH-1:0] writeRegister;
    logic [`DATA_WIDTH-1:0]     writeData;
    logic [`DATA_WIDTH-1:0]     forwardDataExMem;
    logic                       forwardMuxASel;
    logic                       forwardMuxBSel;
    logic                       memReadIdEx;
    logic                       regWriteIdEx;
    logic [1:0]                 regDstIdEx;
    logic [`REG_ADDR_WIDTH-1:0] regRtIdEx;
    logic [`REG_ADDR_WIDTH-1:0] regRdIdEx;
    logic                       regWriteExMem;
    logic                       memReadExMem;
    logic [`REG_ADDR_WIDTH-1:0] registerDstExMem;
    logic [`DATA_WIDTH-1:0]     controlWord;
    logic [`DATA_WIDTH-1:0]     readData1Out;
    logic [`DATA_WIDTH-1:0]     readData2Out;
    logic [`DATA_WIDTH-1:0]     immediate;
    logic                       pcWrite;
    logic                       ifIdWrite;

    logic [`DATA_WIDTH-1:0] model [0:31];     // Register file model
    integer                 seed = 32'h5008;
    logic [5:0] ctrlOps [0:14] = '{`OP_RTYPE, `OP_ADDI, `OP_ANDI, `OP_ORI, `OP_XORI,
                                   `OP_LW, `OP_LH, `OP_LB, `OP_SW, `OP_SH, `OP_SB,
                                   `OP_BEQ, `OP_BNE, `OP_JAL, 6'h3F};  // Last is unknown
    logic [5:0] immOps [0:6] = '{`OP_ANDI, `OP_ORI, `OP_XORI, `OP_ADDI, `OP_LW,
                                 `OP_SW, `OP_BEQ};

    idStage u_dut (
        .Clock (Clock), .reset (reset), .instr (instr),
        .regWrite (regWrite), .writeRegister (writeRegister), .writeData (writeData),
        .forwardDataExMem (forwardDataExMem), .forwardMuxASel (forwardMuxASel),
        .forwardMuxBSel (forwardMuxBSel), .memReadIdEx (memReadIdEx),
        .regWriteIdEx (regWriteIdEx), .regDstIdEx (regDstIdEx), .regRtIdEx (regRtIdEx),
        .regRdIdEx (regRdIdEx), .regWriteExMem (regWriteExMem),
        .memReadExMem (memReadExMem), .registerDstExMem (registerDstExMem),
        .controlWord (controlWord), .readData1Out (readData1Out),
        .readData2Out (readData2Out), .immediate (immediate),
        .pcWrite (pcWrite), .ifIdWrite (ifIdWrite)
    );

    always #50 Clock = ~Clock;                // 100 ns period

    // ------------------------------------------------------------------------
    // Helpers
    // ------------------------------------------------------------------------
    task automatic checkValue(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        assert (got === exp) else begin
            $display("ERROR %s = %h, expected %h", name, got, exp);
            $display("TB FAILED");
            $fatal(1);
        end
    endtask

    function automatic logic [31:0] rType(input logic [4:0] rs, input logic [4:0] rt);
        return {`OP_RTYPE, rs, rt, 5'd3, 5'd0, 6'h20};    // add r3, rs, rt
    endfunction

    function automatic logic [31:0] iType(input logic [5:0] op, input logic [4:0] rs,
                                          input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    // Control word built from the decode table
    function automatic logic [31:0] expectedControl(input logic [5:0] op);
        logic [31:0] cw;
        cw = '0;
        cw[`CW_ALUOP] = op;
        case (op)
            `OP_RTYPE: begin
                cw[`CW_REGDST]   = 2'd1;
                cw[`CW_REGWRITE] = 1'b1;
            end
            `OP_ADDI, `OP_ANDI, `OP_ORI, `OP_XORI: begin
                cw[`CW_ALUSRCB]  = 1'b1;
                cw[`CW_REGWRITE] = 1'b1;
            end
            `OP_LW, `OP_LH, `OP_LB: begin
                cw[`CW_ALUSRCB]  = 1'b1;
                cw[`CW_MEMREAD]  = 1'b1;
                cw[`CW_REGWRITE] = 1'b1;
                cw[`CW_MEMTOREG] = 2'd1;
                cw[`CW_BYTESIZE] = (op == `OP_LH) ? 2'd1 : (op == `OP_LB) ? 2'd2 : 2'd0;
            end
            `OP_SW, `OP_SH, `OP_SB: begin
                cw[`CW_ALUSRCB]  = 1'b1;
                cw[`CW_MEMWRITE] = 1'b1;
                cw[`CW_BYTESIZE] = (op == `OP_SH) ? 2'd1 : (op == `OP_SB) ? 2'd2 : 2'd0;
            end
            `OP_BEQ, `OP_BNE: ;                           // aluOp only
            `OP_JAL: begin
                cw[`CW_REGDST]   = 2'd2;
                cw[`CW_REGWRITE] = 1'b1;
                cw[`CW_MEMTOREG] = 2'd2;
            end
            default: cw = '0;
        endcase
        return cw;
    endfunction

    // Write port cycle with bypass checked on both ports
    task automatic writeReg(input logic [4:0] addr, input logic [31:0] data);
        @(posedge Clock);
        regWrite      <= 1'b1;
        writeRegister <= addr;
        writeData     <= data;
        instr         <= rType(addr, addr);
        @(negedge Clock);
        checkValue("readData1Out", readData1Out, (addr == 0) ? 32'h0 : data);
        checkValue("readData2Out", readData2Out, (addr == 0) ? 32'h0 : data);
        if (addr != 0)
            model[addr] = data;                   // r0 stays zero
    endtask

    task automatic readRegs(input logic [4:0] a, input logic [4:0] b);
        @(posedge Clock);
        regWrite <= 1'b0;
        instr    <= rType(a, b);
        @(negedge Clock);
        checkValue("readData1Out", readData1Out, model[a]);
        checkValue("readData2Out", readData2Out, model[b]);
    endtask

    task automatic hazardCase(input logic [31:0] ins, input logic memRd, input logic regWr,
                              input logic [1:0] dst, input logic [4:0] rtIdEx,
                              input logic [4:0] rdIdEx, input logic wrExMem,
                              input logic rdExMem, input logic [4:0] dstExMem,
                              input logic stall);
        @(posedge Clock);
        instr            <= ins;
        memReadIdEx      <= memRd;
        regWriteIdEx     <= regWr;
        regDstIdEx       <= dst;
        regRtIdEx        <= rtIdEx;
        regRdIdEx        <= rdIdEx;
        regWriteExMem    <= wrExMem;
        memReadExMem     <= rdExMem;
        registerDstExMem <= dstExMem;
        @(negedge Clock);
        checkValue("pcWrite", pcWrite, !stall);
        checkValue("ifIdWrite", ifIdWrite, !stall);
        checkValue("controlWord", controlWord, stall ? 32'h0 : expectedControl(ins[31:26]));
    endtask

    // ------------------------------------------------------------------------
    // Tests
    // ------------------------------------------------------------------------
    task automatic registerReadback;
        for (int i = 0; i < 32; i++)
            readRegs(i, 31 - i);                  // All zero after reset
        writeReg(5, 32'hDEADBEEF);
        readRegs(5, 0);
        writeReg(8, 32'h12345678);
        writeReg(9, 32'h9ABCDEF0);
        readRegs(8, 9);
        writeReg(0, 32'hFFFFFFFF);                // Dropped
        readRegs(0, 0);
    endtask

    task automatic randomRegisterTraffic;
        logic [4:0]  a;
        logic [4:0]  b;
        logic [31:0] d;
        for (int i = 0; i < 64; i++) begin
            a = $random(seed);
            d = $random(seed);
            b = $random(seed);
            writeReg(a, d);
            readRegs(b, a);
        end
    endtask

    task automatic decodeAllOpcodes;
        for (int i = 0; i < 15; i++) begin
            @(posedge Clock);
            instr <= iType(ctrlOps[i], 5'd1, 5'd2, 16'h0040);
            @(negedge Clock);
            checkValue("controlWord", controlWord, expectedControl(ctrlOps[i]));
        end
    endtask

    task automatic stallOnHazards;
        logic [31:0] beq;
        beq = iType(`OP_BEQ, 5'd3, 5'd4, 16'h0010);
        // Load-use on rs and rt but never on r0
        hazardCase(rType(5, 6), 1, 1, 0, 5, 0, 0, 0, 0, 1);
        hazardCase(rType(7, 5), 1, 1, 0, 5, 0, 0, 0, 0, 1);
        hazardCase(rType(0, 0), 1, 1, 0, 0, 0, 0, 0, 0, 0);
        hazardCase(rType(7, 8), 1, 1, 0, 5, 0, 0, 0, 0, 0);
        // Branch against ID/EX destination for rt, rd and r31
        hazardCase(beq, 0, 1, 0, 3, 0, 0, 0, 0, 1);
        hazardCase(beq, 0, 1, 1, 9, 4, 0, 0, 0, 1);
        hazardCase(iType(`OP_BNE, 5'd31, 5'd4, 16'h0008), 0, 1, 2, 9, 9, 0, 0, 0, 1);
        hazardCase(beq, 0, 0, 0, 3, 0, 0, 0, 0, 0);   // No write in EX
        // Branch against EX/MEM stalls on loads only
        hazardCase(beq, 0, 0, 0, 0, 0, 1, 1, 4, 1);
        hazardCase(beq, 0, 0, 0, 0, 0, 1, 0, 4, 0);
        hazardCase(iType(`OP_ADDI, 5'd3, 5'd4, 16'h0001), 0, 1, 0, 3, 0, 0, 0, 0, 0);
        hazardCase(rType(1, 2), 0, 0, 0, 0, 0, 0, 0, 0, 0);   // Back to idle
    endtask

    task automatic forwardOperands;
        logic [31:0] fwd;
        for (int sel = 0; sel < 4; sel++) begin
            fwd = $random(seed);
            @(posedge Clock);
            instr            <= rType(8, 9);
            forwardDataExMem <= fwd;
            forwardMuxASel   <= sel[0];
            forwardMuxBSel   <= sel[1];
            @(negedge Clock);
            checkValue("readData1Out", readData1Out, sel[0] ? fwd : model[8]);
            checkValue("readData2Out", readData2Out, sel[1] ? fwd : model[9]);
        end
    endtask

    task automatic extendImmediates;
        logic [15:0] imm;
        logic [31:0] exp;
        logic        logical;
        for (int i = 0; i < 7; i++) begin
            for (int j = 0; j < 8; j++) begin
                imm     = $random(seed);
                logical = (immOps[i] == `OP_ANDI) || (immOps[i] == `OP_ORI)
                       || (immOps[i] == `OP_XORI);
                exp     = logical ? {16'h0, imm} : {{16{imm[15]}}, imm};
                @(posedge Clock);
                instr <= iType(immOps[i], 5'd1, 5'd2, imm);
                @(negedge Clock);
                checkValue("immediate", immediate, exp);
            end
        end
    endtask

    // Watchdog
    initial begin
        #(TOTAL_CYCLES * 100);
        $display("Timeout, the tests did not finish within the expected time");
        $display("TB FAILED");
        $fatal(1);
    end

    initial begin
        reset = 1'b1;
        instr = '0;
        regWrite = 1'b0;
        writeRegister = '0;
        writeData = '0;
        forwardDataExMem = '0;
        forwardMuxASel = 1'b0;
        forwardMuxBSel = 1'b0;
        memReadIdEx = 1'b0;
        regWriteIdEx = 1'b0;
        regDstIdEx = 2'd0;
        regRtIdEx = '0;
        regRdIdEx = '0;
        regWriteExMem = 1'b0;
        memReadExMem = 1'b0;
        registerDstExMem = '0;
        for (int i = 0; i < 32; i++)
            model[i] = '0;
        repeat (RESET_CYCLES) @(posedge Clock);
        reset <= 1'b0;
        registerReadback();
        randomRegisterTraffic();
        decodeAllOpcodes();
        stallOnHazards();
        forwardOperands();
        extendImmediates();
        $display("TB PASSED");
        $finish;
    end

endmodule

`default_nettype wire
